/* bench/riscCore_asserts.sv */
//**********************************************************
// Bound checks on reset state, x0 reads and byte enables
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "riscCore_defs.svh"

module riscCoreAsserts
   import riscPkg::*;
(
   input wire logic    clk,
   input wire logic    rst,
   input wire word_t   instAddr,
   input wire byteEn_t dataWe,
   input wire logic    retireValid,
   input wire regIdx_t rs1,
   input wire regIdx_t rs2,
   input wire word_t   rs1Val,
   input wire word_t   rs2Val
);

   // Core restarts at the reset address
   resetPc: assert property (@(posedge clk) rst |=> instAddr == `RESET_PC)
      else $error("instAddr not at reset address after reset");

   // Two empty cycles before the first retire
   resetQuiet: assert property (@(posedge clk) $fell(rst) |-> !retireValid && dataWe == 4'b0000
      ##1 !retireValid)
      else $error("retire or write too early after reset");

   // Operands naming x0 stay zero even while writeback targets x0
   zeroRs1: assert property (@(posedge clk) disable iff (rst) rs1 == 5'd0 |-> rs1Val == '0)
      else $error("x0 operand rs1 read back nonzero");

   zeroRs2: assert property (@(posedge clk) disable iff (rst) rs2 == 5'd0 |-> rs2Val == '0)
      else $error("x0 operand rs2 read back nonzero");

   legalBe: assert property (@(posedge clk) disable iff (rst)
      dataWe inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
      else $error("illegal byte enable pattern");

endmodule

`default_nettype wire

/* bench/riscCore_tb.sv */
//**********************************************************
// Testbench for riscCore with random program, memories,
// instruction-set model and typed compare tasks
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "riscCore_defs.svh"

module riscCore_tb
   import riscPkg::*;
;

   localparam int ProgLen = 300;

   logic    clk = 1'b0;
   logic    rst;
   word_t   instAddr;
   word_t   instData = '0;
   word_t   dataAddr;
   byteEn_t dataWe;
   logic    dataRe;
   word_t   dataWdata;
   word_t   dataRdata = '0;
   logic    retireValid;
   word_t   retirePc;
   logic    retireWe;
   regIdx_t retireRd;
   word_t   retireData;

   word_t   imem [512];
   word_t   dmem [256];
   word_t   prog [512];
   word_t   mdmem [256];
   word_t   mreg [32];
   word_t   mpc;
   word_t   seed = 32'h5734264b;
   word_t   mergeWord;
   word_t   stAddr [$];
   word_t   stData [$];
   byteEn_t stBe [$];
   word_t   ldAddr [$];

   riscCore DUT (
      .clk(clk), .rst(rst), .instAddr(instAddr), .instData(instData),
      .dataAddr(dataAddr), .dataWe(dataWe), .dataRe(dataRe), .dataWdata(dataWdata),
      .dataRdata(dataRdata), .retireValid(retireValid), .retirePc(retirePc),
      .retireWe(retireWe), .retireRd(retireRd), .retireData(retireData)
   );

   bind riscCore riscCoreAsserts checks (
      .clk(clk), .rst(rst), .instAddr(instAddr), .dataWe(dataWe),
      .retireValid(retireValid), .rs1(rs1), .rs2(rs2), .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   always #2 clk = !clk;

   // Both memories answer one edge after the request
   always @(posedge clk)
   begin
      instData <= imem[instAddr[10:2]];
      dataRdata <= dmem[dataAddr[9:2]];
      mergeWord = dmem[dataAddr[9:2]];
      for (int b = 0; b < 4; b++)
      begin
         if (dataWe[b])
            mergeWord[8*b +: 8] = dataWdata[8*b +: 8];
      end
      dmem[dataAddr[9:2]] <= mergeWord;
   end

   // Data accesses are logged in execute and matched at retire
   always @(negedge clk)
   begin
      if (!rst && dataWe != 4'b0000)
      begin
         stAddr.push_back(dataAddr);
         stData.push_back(dataWdata);
         stBe.push_back(dataWe);
      end
      if (!rst && dataRe)
         ldAddr.push_back(dataAddr);
   end

   function word_t nextRand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("Error: %s got %h expected %h", name, got, exp);
         failRun("word mismatch");
      end
   endtask

   task automatic checkReg(input string name, input regIdx_t got, input regIdx_t exp);
      if (got !== exp)
      begin
         $display("Error: %s got %h expected %h", name, got, exp);
         failRun("register index mismatch");
      end
   endtask

   task automatic checkByteEn(input string name, input byteEn_t got, input byteEn_t exp);
      if (got !== exp)
      begin
         $display("Error: %s got %h expected %h", name, got, exp);
         failRun("byte enable mismatch");
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("Error: %s got %h expected %h", name, got, exp);
         failRun("flag mismatch");
      end
   endtask

   // Reference arithmetic straight from the ISA rules
   function automatic word_t arith(input logic [2:0] f3, input logic alt,
                                   input word_t a, input word_t b);
      case (f3)
         3'd0:    return alt ? a - b : a + b;
         3'd1:    return a << b[4:0];
         3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3:    return (a < b) ? 32'd1 : 32'd0;
         3'd4:    return a ^ b;
         3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
         3'd6:    return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic branchCond(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0:    return a == b;
         3'd1:    return a != b;
         3'd4:    return $signed(a) < $signed(b);
         3'd5:    return $signed(a) >= $signed(b);
         3'd6:    return a < b;
         default: return a >= b;
      endcase
   endfunction

   task automatic buildProgram();
      word_t r;
      word_t inst;
      int    tgt;
      logic [4:0] rd;
      logic [4:0] ra;
      logic [4:0] rb;
      logic [2:0] f3;
      logic [11:0] off;
      logic [12:0] boff;
      logic [20:0] joff;
      for (int i = 0; i < 512; i++)
         prog[i] = `NOP_INST;
      for (int i = 0; i < ProgLen - 1; i++)
      begin
         r = nextRand();
         // Few registers, so neighbours depend on each other often
         rd = {2'b00, r[7:5]};
         ra = {2'b00, r[10:8]};
         rb = {2'b00, r[13:11]};
         f3 = r[16:14];
         tgt = i + 1 + int'(r[19:17] % 6);
         if (tgt > ProgLen - 1)
            tgt = ProgLen - 1;
         case (r[3:0])
            4'd0, 4'd1, 4'd2, 4'd3:
               inst = {1'b0, (f3 == 3'd0 || f3 == 3'd5) && r[20], 5'd0, rb, ra, f3, rd, OpReg};
            4'd4, 4'd5, 4'd6:
            begin
               if (f3 == 3'd1 || f3 == 3'd5)
                  off = {1'b0, f3 == 3'd5 && r[20], 5'd0, r[25:21]};
               else
                  off = r[31:20];
               inst = {off, ra, f3, rd, OpImm};
            end
            4'd7:    inst = {r[31:12], rd, OpLui};
            4'd8:    inst = {r[31:12], rd, OpAuipc};
            4'd9, 4'd10:
            begin
               f3 = (r[16:14] % 5 > 2) ? {1'b1, 1'b0, r[14]} : 3'(r[16:14] % 3);
               off = 12'h100 + r[31:24];
               off = (f3[1:0] == 2'd2) ? off & ~12'd3 : (f3[0] ? off & ~12'd1 : off);
               inst = {off, 5'd0, f3, rd, OpLoad};
            end
            4'd11:
            begin
               f3 = 3'(r[16:14] % 3);
               off = 12'h100 + r[31:24];
               off = (f3 == 3'd2) ? off & ~12'd3 : (f3[0] ? off & ~12'd1 : off);
               inst = {off[11:5], rb, 5'd0, f3, off[4:0], OpStore};
            end
            4'd12, 4'd13:
            begin
               if (f3 == 3'd2 || f3 == 3'd3)
                  f3 = 3'd0;
               boff = 13'((tgt - i) * 4);
               inst = {boff[12], boff[10:5], rb, ra, f3, boff[4:1], boff[11], OpBranch};
            end
            4'd14:
            begin
               joff = 21'((tgt - i) * 4);
               inst = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OpJal};
            end
            default: inst = {12'(tgt * 4), 5'd0, 3'd0, rd, OpJalr};
         endcase
         prog[i] = inst;
      end
      // Final self-jump
      prog[ProgLen - 1] = {20'd0, 5'd0, OpJal};
   endtask

   // Steps one instruction and checks it against the retire port
   task automatic stepAndCheck();
      word_t inst;
      word_t a;
      word_t b;
      word_t val;
      word_t addr;
      word_t nextPc;
      word_t mword;
      word_t mask;
      byteEn_t be;
      logic  we;
      logic [2:0] f3;
      logic [7:0] bt;
      logic [15:0] hw;
      inst = prog[mpc[10:2]];
      f3 = inst[14:12];
      a = mreg[inst[19:15]];
      b = mreg[inst[24:20]];
      nextPc = mpc + 4;
      we = 1'b0;
      val = '0;
      case (inst[6:0])
         OpLui:
         begin
            we = 1'b1;
            val = {inst[31:12], 12'd0};
         end
         OpAuipc:
         begin
            we = 1'b1;
            val = mpc + {inst[31:12], 12'd0};
         end
         OpJal:
         begin
            we = 1'b1;
            val = mpc + 4;
            nextPc = mpc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
         end
         OpJalr:
         begin
            we = 1'b1;
            val = mpc + 4;
            nextPc = (a + {{20{inst[31]}}, inst[31:20]}) & ~32'd1;
         end
         OpBranch:
            if (branchCond(f3, a, b))
               nextPc = mpc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
         OpLoad:
         begin
            we = 1'b1;
            addr = a + {{20{inst[31]}}, inst[31:20]};
            if (ldAddr.size() == 0)
               failRun("load retired without a data read");
            checkWord("dataAddr", ldAddr.pop_front(), {addr[31:2], 2'b00});
            mword = mdmem[addr[9:2]];
            bt = mword[8*addr[1:0] +: 8];
            hw = mword[16*addr[1] +: 16];
            case (f3)
               3'd0:    val = {{24{bt[7]}}, bt};
               3'd1:    val = {{16{hw[15]}}, hw};
               3'd4:    val = {24'd0, bt};
               3'd5:    val = {16'd0, hw};
               default: val = mword;
            endcase
         end
         OpStore:
         begin
            addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
            be = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
                 (f3 == 3'd1) ? 4'b0011 << {addr[1], 1'b0} : 4'b1111;
            mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
            b = b << (8 * addr[1:0]);
            mdmem[addr[9:2]] = (mdmem[addr[9:2]] & ~mask) | (b & mask);
            if (stBe.size() == 0)
               failRun("store retired without a data write");
            checkWord("dataAddr", stAddr.pop_front(), {addr[31:2], 2'b00});
            checkByteEn("dataWe", stBe.pop_front(), be);
            checkWord("dataWdata", stData.pop_front() & mask, b & mask);
         end
         OpImm:
         begin
            we = 1'b1;
            val = arith(f3, f3 == 3'd5 && inst[30], a, {{20{inst[31]}}, inst[31:20]});
         end
         default:
         begin
            we = 1'b1;
            val = arith(f3, inst[30], a, b);
         end
      endcase
      checkWord("retirePc", retirePc, mpc);
      checkFlag("retireWe", retireWe, we);
      if (we)
      begin
         checkReg("retireRd", retireRd, inst[11:7]);
         checkWord("retireData", retireData, val);
         if (inst[11:7] != 5'd0)
            mreg[inst[11:7]] = val;
      end
      mpc = nextPc;
   endtask

   initial
   begin
      int waited;
      logic finished;
      rst = 1'b1;
      buildProgram();
      for (int i = 0; i < 512; i++)
         imem[i] = prog[i];
      for (int i = 0; i < 256; i++)
      begin
         // Fill pattern spreads the word index over every byte
         dmem[i] = (i * 32'h9e3779b1) ^ {8'(i), 8'(~i), 8'(i + 3), 8'(i * 7)};
         mdmem[i] = dmem[i];
      end
      for (int i = 0; i < 32; i++)
         mreg[i] = '0;
      mpc = `RESET_PC;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      checkWord("instAddr", instAddr, `RESET_PC);
      checkFlag("retireValid", retireValid, 1'b0);
      checkByteEn("dataWe", dataWe, 4'b0000);
      @(negedge clk);
      checkFlag("retireValid", retireValid, 1'b0);
      finished = 1'b0;
      while (!finished)
      begin
         waited = 0;
         @(negedge clk);
         while (!retireValid)
         begin
            waited++;
            if (waited > 20)
               failRun("timeout waiting for an instruction to retire");
            @(negedge clk);
         end
         finished = (mpc == (ProgLen - 1) * 4);
         stepAndCheck();
      end
      // Every logged access must belong to a retired load or store
      if (stBe.size() != 0 || ldAddr.size() != 0)
         failRun("data access made by an instruction that is not a load or store");
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* hw/alu.sv */
//**********************************************************
// Integer ALU with branch condition evaluation
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module alu
   import riscPkg::*;
(
   input  word_t      a,
   input  word_t      b,
   input  aluOp_t     op,
   input  logic [2:0] funct3,
   output word_t      result,
   output logic       branchTaken
);

   logic [4:0] shamt;
   logic       isEq;
   logic       isLt;
   logic       isLtu;

   assign shamt = b[4:0];
   assign isEq  = (a == b);
   assign isLt  = ($signed(a) < $signed(b));
   assign isLtu = (a < b);

   always_comb
   begin
      case (op)
         AluAdd:   result = a + b;
         AluSub:   result = a - b;
         AluSll:   result = a << shamt;
         AluSlt:   result = {31'd0, isLt};
         AluSltu:  result = {31'd0, isLtu};
         AluXor:   result = a ^ b;
         AluSrl:   result = a >> shamt;
         AluSra:   result = word_t'($signed(a) >>> shamt);
         AluOr:    result = a | b;
         AluAnd:   result = a & b;
         AluPassB: result = b;
         default:  result = '0;
      endcase
   end

   // Condition only, the core decides whether this is a branch
   always_comb
   begin
      case (funct3)
         3'b000:  branchTaken = isEq;
         3'b001:  branchTaken = !isEq;
         3'b100:  branchTaken = isLt;
         3'b101:  branchTaken = !isLt;
         3'b110:  branchTaken = isLtu;
         3'b111:  branchTaken = !isLtu;
         default: branchTaken = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

/* hw/instDecoder.sv */
//**********************************************************
// Instruction decoder with immediate generation
// Produces all execute and writeback controls
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module instDecoder
   import riscPkg::*;
(
   input  word_t      inst,
   output regIdx_t    rs1,
   output regIdx_t    rs2,
   output regIdx_t    rd,
   output word_t      imm,
   output aluOp_t     aluOp,
   output logic       srcAPc,
   output logic       srcBImm,
   output logic       regWe,
   output logic       isBranch,
   output logic       isJal,
   output logic       isJalr,
   output logic       isLoad,
   output logic       isStore,
   output logic [2:0] memFunct3,
   output wbSel_t     wbSel
);

   opcode_t    opcode;
   logic [2:0] funct3;
   logic       funct7b5;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;

   // Register and immediate forms share this mapping
   function automatic aluOp_t arithOp(input logic [2:0] f3, input logic alt);
      case (f3)
         3'b000:  return alt ? AluSub : AluAdd;
         3'b001:  return AluSll;
         3'b010:  return AluSlt;
         3'b011:  return AluSltu;
         3'b100:  return AluXor;
         3'b101:  return alt ? AluSra : AluSrl;
         3'b110:  return AluOr;
         default: return AluAnd;
      endcase
   endfunction

   assign opcode    = opcode_t'(inst[6:0]);
   assign funct3    = inst[14:12];
   assign funct7b5  = inst[30];
   assign rs1       = inst[19:15];
   assign rs2       = inst[24:20];
   assign rd        = inst[11:7];
   assign memFunct3 = funct3;

   assign immI = {{20{inst[31]}}, inst[31:20]};
   assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
   assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
   assign immU = {inst[31:12], 12'd0};
   assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

   always_comb
   begin
      imm      = immI;
      aluOp    = AluAdd;
      srcAPc   = 1'b0;
      srcBImm  = 1'b0;
      regWe    = 1'b0;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      wbSel    = WbAlu;
      case (opcode)
         OpLui:
         begin
            imm     = immU;
            aluOp   = AluPassB;
            srcBImm = 1'b1;
            regWe   = 1'b1;
         end
         OpAuipc:
         begin
            imm     = immU;
            srcAPc  = 1'b1;
            srcBImm = 1'b1;
            regWe   = 1'b1;
         end
         OpJal:
         begin
            imm   = immJ;
            isJal = 1'b1;
            regWe = 1'b1;
            wbSel = WbLink;
         end
         OpJalr:
         begin
            srcBImm = 1'b1;
            isJalr  = 1'b1;
            regWe   = 1'b1;
            wbSel   = WbLink;
         end
         OpBranch:
         begin
            imm      = immB;
            isBranch = 1'b1;
         end
         OpLoad:
         begin
            srcBImm = 1'b1;
            isLoad  = 1'b1;
            regWe   = 1'b1;
            wbSel   = WbLoad;
         end
         OpStore:
         begin
            imm     = immS;
            srcBImm = 1'b1;
            isStore = 1'b1;
         end
         OpImm:
         begin
            // Bit 30 selects SRAI only, elsewhere it is immediate
            aluOp   = arithOp(funct3, funct3 == 3'b101 && funct7b5);
            srcBImm = 1'b1;
            regWe   = 1'b1;
         end
         OpReg:
         begin
            aluOp = arithOp(funct3, funct7b5);
            regWe = 1'b1;
         end
         default:
         begin
            regWe = 1'b0;
         end
      endcase
   end

endmodule

`default_nettype wire

/* hw/loadStoreUnit.sv */
//**********************************************************
// Store lane alignment and load extraction with extension
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit
   import riscPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  word_t      addr,
   input  word_t      storeData,
   input  logic [2:0] funct3,
   input  logic       isStore,
   input  logic       isLoad,
   output byteEn_t    dataWe,
   output word_t      dataWdata,
   output logic       dataRe,
   input  word_t      dataRdata,
   output word_t      loadResult
);

   byteEn_t    storeMask;
   logic [1:0] offsetWb;
   logic [2:0] funct3Wb;
   logic [7:0] loadByte;
   logic [15:0] loadHalf;

   // Size in funct3[1:0], low address bits pick the lanes
   always_comb
   begin
      case (funct3[1:0])
         2'b00:
         begin
            storeMask = 4'b0001 << addr[1:0];
            dataWdata = {4{storeData[7:0]}};
         end
         2'b01:
         begin
            storeMask = addr[1] ? 4'b1100 : 4'b0011;
            dataWdata = {2{storeData[15:0]}};
         end
         default:
         begin
            storeMask = 4'b1111;
            dataWdata = storeData;
         end
      endcase
   end

   assign dataWe = isStore ? storeMask : 4'b0000;
   assign dataRe = isLoad;

   // Lane select travels with the load into writeback
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         offsetWb <= 2'd0;
         funct3Wb <= 3'd0;
      end
      else
      begin
         offsetWb <= addr[1:0];
         funct3Wb <= funct3;
      end
   end

   assign loadByte = dataRdata[{offsetWb, 3'b000} +: 8];
   assign loadHalf = offsetWb[1] ? dataRdata[31:16] : dataRdata[15:0];

   always_comb
   begin
      case (funct3Wb)
         3'b000:  loadResult = {{24{loadByte[7]}}, loadByte};
         3'b001:  loadResult = {{16{loadHalf[15]}}, loadHalf};
         3'b100:  loadResult = {24'd0, loadByte};
         3'b101:  loadResult = {16'd0, loadHalf};
         default: loadResult = dataRdata;
      endcase
   end

endmodule

`default_nettype wire

/* hw/regFile.sv */
//**********************************************************
// 32 x 32 register file, two read ports and one write port
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

module regFile
   import riscPkg::*;
(
   input  logic    clk,
   input  logic    we,
   input  regIdx_t ra1,
   input  regIdx_t ra2,
   input  regIdx_t wa,
   input  word_t   wd,
   output word_t   rd1,
   output word_t   rd2
);

   word_t regs [32];

   // Entry 0 is never written
   always_ff @(posedge clk)
   begin
      if (we && wa != 5'd0)
      begin
         regs[wa] <= wd;
      end
   end

   // x0 always reads as zero
   assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* hw/riscCore.sv */
//**********************************************************
// Three-stage RV32I core top level
// Fetch, execute and writeback with writeback forwarding
//**********************************************************

`timescale 1ns/1ps
`default_nettype none

`include "riscCore_defs.svh"

module riscCore
   import riscPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   output word_t   instAddr,
   input  word_t   instData,
   output word_t   dataAddr,
   output byteEn_t dataWe,
   output logic    dataRe,
   output word_t   dataWdata,
   input  word_t   dataRdata,
   output logic    retireValid,
   output word_t   retirePc,
   output logic    retireWe,
   output regIdx_t retireRd,
   output word_t   retireData
);

   // Fetch and execute
   word_t      pc;
   word_t      pcEx;
   logic       killEx;
   word_t      instEx;
   regIdx_t    rs1;
   regIdx_t    rs2;
   regIdx_t    rd;
   word_t      imm;
   aluOp_t     aluOp;
   logic       srcAPc;
   logic       srcBImm;
   logic       regWe;
   logic       isBranch;
   logic       isJal;
   logic       isJalr;
   logic       isLoad;
   logic       isStore;
   logic [2:0] funct3Ex;
   wbSel_t     wbSel;
   word_t      rd1;
   word_t      rd2;
   word_t      rs1Val;
   word_t      rs2Val;
   word_t      aluA;
   word_t      aluB;
   word_t      aluResult;
   logic       branchTaken;
   logic       redirect;
   word_t      target;

   // Writeback
   logic       validWb;
   logic       regWeWb;
   word_t      pcWb;
   regIdx_t    rdWb;
   wbSel_t     wbSelWb;
   word_t      aluWb;
   word_t      linkWb;
   word_t      loadResult;
   word_t      wbData;

   assign instAddr = pc;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         pc     <= `RESET_PC;
         killEx <= 1'b1;
      end
      else
      begin
         pc     <= redirect ? target : pc + 32'd4;
         killEx <= redirect;
      end
      pcEx <= pc;
   end

   // Slot fetched under a redirect becomes a bubble
   assign instEx = killEx ? `NOP_INST : instData;

   instDecoder decoder (
      .inst(instEx), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
      .aluOp(aluOp), .srcAPc(srcAPc), .srcBImm(srcBImm), .regWe(regWe),
      .isBranch(isBranch), .isJal(isJal), .isJalr(isJalr),
      .isLoad(isLoad), .isStore(isStore), .memFunct3(funct3Ex), .wbSel(wbSel)
   );

   regFile regs (
      .clk(clk), .we(regWeWb), .ra1(rs1), .ra2(rs2), .wa(rdWb), .wd(wbData),
      .rd1(rd1), .rd2(rd2)
   );

   // Writeback result bypasses the register file, load data included
   assign rs1Val = (regWeWb && rdWb != 5'd0 && rdWb == rs1) ? wbData : rd1;
   assign rs2Val = (regWeWb && rdWb != 5'd0 && rdWb == rs2) ? wbData : rd2;

   assign aluA = srcAPc ? pcEx : rs1Val;
   assign aluB = srcBImm ? imm : rs2Val;

   alu alu (
      .a(aluA), .b(aluB), .op(aluOp), .funct3(funct3Ex),
      .result(aluResult), .branchTaken(branchTaken)
   );

   assign redirect = (isBranch && branchTaken) || isJal || isJalr;
   assign target   = isJalr ? {aluResult[31:1], 1'b0} : pcEx + imm;

   assign dataAddr = {aluResult[31:2], 2'b00};

   loadStoreUnit lsu (
      .clk(clk), .rst(rst), .addr(aluResult), .storeData(rs2Val),
      .funct3(funct3Ex), .isStore(isStore), .isLoad(isLoad),
      .dataWe(dataWe), .dataWdata(dataWdata), .dataRe(dataRe),
      .dataRdata(dataRdata), .loadResult(loadResult)
   );

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         validWb <= 1'b0;
         regWeWb <= 1'b0;
      end
      else
      begin
         validWb <= !killEx;
         regWeWb <= regWe && !killEx;
      end
      pcWb    <= pcEx;
      rdWb    <= rd;
      wbSelWb <= wbSel;
      aluWb   <= aluResult;
      linkWb  <= pcEx + 32'd4;
   end

   always_comb
   begin
      case (wbSelWb)
         WbLoad:  wbData = loadResult;
         WbLink:  wbData = linkWb;
         default: wbData = aluWb;
      endcase
   end

   assign retireValid = validWb;
   assign retirePc    = pcWb;
   assign retireWe    = regWeWb;
   assign retireRd    = rdWb;
   assign retireData  = wbData;

endmodule

`default_nettype wire

/* hw/riscCore_defs.svh */
//**********************************************************
// Reset fetch address and no-operation encoding for the core
//**********************************************************

`ifndef RISCCORE_DEFS_SVH
`define RISCCORE_DEFS_SVH

// First instruction address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
// Replaces the instruction in a killed fetch slot
`define NOP_INST 32'h0000_0013

`endif

/* hw/riscPkg.sv */
//**********************************************************
// Shared types for the RV32I core
// Word, register index, opcode, ALU op and writeback select
//**********************************************************

`default_nettype none

package riscPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regIdx_t;
   typedef logic [3:0]  byteEn_t;

   // Major opcodes of the supported subset
   typedef enum logic [6:0] {
      OpLui    = 7'b0110111,
      OpAuipc  = 7'b0010111,
      OpJal    = 7'b1101111,
      OpJalr   = 7'b1100111,
      OpBranch = 7'b1100011,
      OpLoad   = 7'b0000011,
      OpStore  = 7'b0100011,
      OpImm    = 7'b0010011,
      OpReg    = 7'b0110011
   } opcode_t;

   typedef enum logic [3:0] {
      AluAdd, AluSub, AluSll, AluSlt, AluSltu, AluXor,
      AluSrl, AluSra, AluOr, AluAnd, AluPassB
   } aluOp_t;

   // Source of the register write value
   typedef enum logic [1:0] {
      WbAlu  = 2'd0,
      WbLoad = 2'd1,
      WbLink = 2'd2
   } wbSel_t;

endpackage

`default_nettype wire

/* riscCore.f */
+incdir+hw
hw/riscPkg.sv
hw/regFile.sv
hw/alu.sv
hw/instDecoder.sv
hw/loadStoreUnit.sv
hw/riscCore.sv
bench/riscCore_asserts.sv
bench/riscCore_tb.sv
